/* verif/exec_golden.txt */
# unit(0 add, 1 logic) pair op rs1 rs2 tag result branch, all hex
# pair 1 issues the line in the same cycle as the next line
0 1 0 00000064 0000000a 1 0000006e 0
1 0 0 0000ffff 12345678 2 00005678 0
0 0 0 00000005 00000003 1 00000008 0
0 0 0 ffffffff 00000001 2 00000000 0
0 0 0 7fffffff 00000001 3 80000000 0
0 0 0 12345678 87654321 4 99999999 0
0 0 0 80000000 80000000 5 00000000 0
0 0 1 00000003 00000005 6 fffffffe 0
0 0 1 00000000 00000001 7 ffffffff 0
0 0 1 80000000 00000001 8 7fffffff 0
0 0 1 deadbeef deadbeef 9 00000000 0
0 0 1 12345678 00000078 a 12345600 0
0 0 2 00000010 00000010 b 00000000 0
0 0 2 00000010 00000011 c ffffffff 1
0 0 4 abcd0000 abcd0000 d 00000000 1
0 0 4 00000001 00000000 e 00000001 0
0 0 6 00000001 00000002 f ffffffff 1
0 0 6 00000002 00000001 0 00000001 0
0 0 6 80000000 00000001 1 7fffffff 1
0 0 6 7fffffff ffffffff 2 80000000 0
0 0 6 ffffffff 00000000 3 ffffffff 1
0 0 6 80000000 80000000 4 00000000 0
0 0 6 80000000 7fffffff 5 00000001 1
1 0 0 f0f0f0f0 ff00ff00 6 f000f000 0
1 0 1 f0f0f0f0 0f0f0000 7 fffff0f0 0
1 0 2 aaaaaaaa ffff0000 8 5555aaaa 0
1 0 3 00000001 0000001f 9 80000000 0
1 0 3 12345678 00000024 a 23456780 0
1 0 4 80000000 0000001f b 00000001 0
1 0 4 12345678 00000108 c 00123456 0
1 0 3 deadbeef 00000020 d deadbeef 0
1 0 4 ffffffff 00000004 e 0fffffff 0
1 0 2 12345678 12345678 f 00000000 0
1 1 3 00000003 00000002 3 0000000c 0
0 0 1 00000064 00000065 4 ffffffff 0
0 0 0 00000100 00000100 5 00000200 0
0 1 6 00000005 fffffffb 6 0000000a 0
1 0 1 00000000 00000000 7 00000000 0
0 1 4 00000007 00000007 8 00000000 1
1 0 4 80000000 00000001 9 40000000 0
1 1 2 ffffffff 0f0f0f0f a f0f0f0f0 0
0 0 2 00000000 00000001 b ffffffff 1
1 0 0 ffffffff 00000001 c 00000001 0
0 1 0 7fffffff 7fffffff d fffffffe 0
1 0 3 0000ffff 00000010 e ffff0000 0

/* src.f */
source/cpu_pkg.sv
source/exec_op_pkg.sv
source/add_sub_core.sv
source/add_unit.sv
source/logic_unit.sv
source/cdb_arbiter.sv
source/exec_cluster.sv
verif/exec_cluster_tb.sv

/* Bender.yml */
package:
  name: exec_cluster

sources:
  # packages first, then the units and the top level
  - source/cpu_pkg.sv
  - source/exec_op_pkg.sv
  - source/add_sub_core.sv
  - source/add_unit.sv
  - source/logic_unit.sv
  - source/cdb_arbiter.sv
  - source/exec_cluster.sv

  # testbench, reads verif/exec_golden.txt at run time
  - target: test
    files:
      - verif/exec_cluster_tb.sv

/* verif/exec_cluster_tb.sv */
// testbench for the integer execute cluster
// replays each op of verif/exec_golden.txt and compares what comes back on the bus
// paired lines are issued in one cycle to exercise the round-robin arbiter
`timescale 1ns/100ps

module exec_cluster_tb;

	logic clk;
	logic rst;
	logic add_valid_in, log_valid_in;
	exec_op_pkg::exec_op_u add_op, log_op;
	cpu_pkg::rob_tag_t add_rob_tag, log_rob_tag;
	cpu_pkg::word_t add_rs1, add_rs2, log_rs1, log_rs2;
	logic add_ready, log_ready;
	logic cdb_valid;
	cpu_pkg::rob_tag_t cdb_tag;
	cpu_pkg::word_t cdb_result;
	logic cdb_branch_taken;

	// one golden entry per data line
	bit g_unit[$]; // 0 add unit, 1 logic unit
	bit g_pair[$];
	logic [2:0] g_op[$];
	cpu_pkg::word_t g_rs1[$], g_rs2[$], g_res[$];
	cpu_pkg::rob_tag_t g_tag[$];
	logic g_br[$];

	logic [31:0] rng;
	bit last_log; // unit of the previous grant
	int n_ops_done;
	int idx;

	exec_cluster u_exec_cluster (
		.clk              (clk),
		.rst              (rst),
		.add_valid_in     (add_valid_in),
		.add_op           (add_op),
		.add_rob_tag      (add_rob_tag),
		.add_rs1          (add_rs1),
		.add_rs2          (add_rs2),
		.add_ready        (add_ready),
		.log_valid_in     (log_valid_in),
		.log_op           (log_op),
		.log_rob_tag      (log_rob_tag),
		.log_rs1          (log_rs1),
		.log_rs2          (log_rs2),
		.log_ready        (log_ready),
		.cdb_valid        (cdb_valid),
		.cdb_tag          (cdb_tag),
		.cdb_result       (cdb_result),
		.cdb_branch_taken (cdb_branch_taken)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic cpu_pkg::word_t bit_word(input logic b);
		return {{(cpu_pkg::xlen-1){1'b0}}, b};
	endfunction

	function automatic logic ready_of(input bit unit);
		return unit ? log_ready : add_ready;
	endfunction

	function automatic string op_name(input int i);
		return $sformatf("op %0d", i);
	endfunction

	task automatic check_word(input string name, input cpu_pkg::word_t exp,
			input cpu_pkg::word_t act);
		if (act !== exp) begin
			$display("error %s expected %h actual %h", name, exp, act);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_tag(input string name, input cpu_pkg::rob_tag_t exp,
			input cpu_pkg::rob_tag_t act);
		if (act !== exp) begin
			$display("error %s expected %h actual %h", name, exp, act);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic load_golden();
		int fd;
		int got;
		int n;
		int line_no;
		logic [8*256-1:0] line;
		logic [31:0] u, p, o, a, b, t, r, br;
		line_no = 0;
		fd = $fopen("verif/exec_golden.txt", "r");
		if (fd == 0)
			abort_run("could not open verif/exec_golden.txt");
		while (!$feof(fd)) begin
			line = '0;
			got = $fgets(line, fd);
			line_no++;
			if (got > 0) begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h", u, p, o, a, b, t, r, br);
				if (n == 8) begin
					g_unit.push_back(u[0]);
					g_pair.push_back(p[0]);
					g_op.push_back(o[2:0]);
					g_rs1.push_back(a);
					g_rs2.push_back(b);
					g_tag.push_back(t[cpu_pkg::rob_tag_w-1:0]);
					g_res.push_back(r);
					g_br.push_back(br[0]);
				end else if (n > 0) begin
					abort_run($sformatf("golden line %0d has too few columns", line_no));
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic drive_issue(input int i);
		if (g_unit[i]) begin
			log_valid_in = 1'b1;
			log_op = g_op[i];
			log_rob_tag = g_tag[i];
			log_rs1 = g_rs1[i];
			log_rs2 = g_rs2[i];
		end else begin
			add_valid_in = 1'b1;
			add_op = g_op[i];
			add_rob_tag = g_tag[i];
			add_rs1 = g_rs1[i];
			add_rs2 = g_rs2[i];
		end
	endtask

	task automatic clear_issue();
		add_valid_in = 1'b0;
		log_valid_in = 1'b0;
	endtask

	task automatic wait_ready(input bit unit);
		int cycles;
		cycles = 0;
		while (!ready_of(unit)) begin
			if (cycles == 50) begin
				abort_run("timeout waiting for ready");
			end else begin
				step();
				cycles++;
			end
		end
	endtask

	task automatic wait_cdb();
		int cycles;
		cycles = 0;
		while (!cdb_valid) begin
			if (cycles == 50) begin
				abort_run("timeout waiting for cdb_valid");
			end else begin
				step();
				cycles++;
			end
		end
	endtask

	task automatic check_result(input int i);
		string nm;
		nm = op_name(i);
		check_tag({nm, " tag"}, g_tag[i], cdb_tag);
		check_word({nm, " result"}, g_res[i], cdb_result);
		check_word({nm, " branch"}, bit_word(g_br[i]), bit_word(cdb_branch_taken));
		n_ops_done++;
	endtask

	task automatic run_single(input int i);
		bit u;
		u = g_unit[i];
		wait_ready(u);
		drive_issue(i);
		step();
		clear_issue();
		check_word({op_name(i), " ready after issue"}, '0, bit_word(ready_of(u)));
		wait_cdb();
		check_result(i);
		last_log = u;
		step();
		check_word({op_name(i), " ready after bus"}, 1, bit_word(ready_of(u)));
	endtask

	task automatic run_pair(input int i, input int j);
		int first, second;
		if (g_unit[i] == g_unit[j])
			abort_run($sformatf("golden pair at op %0d names one unit twice", i));
		wait_ready(g_unit[i]);
		wait_ready(g_unit[j]);
		drive_issue(i);
		drive_issue(j);
		step();
		clear_issue();
		check_word({op_name(i), " ready after issue"}, '0, bit_word(ready_of(g_unit[i])));
		check_word({op_name(j), " ready after issue"}, '0, bit_word(ready_of(g_unit[j])));
		// tie goes to the unit not granted last
		if (g_unit[i] != last_log) begin
			first = i;
			second = j;
		end else begin
			first = j;
			second = i;
		end
		wait_cdb();
		check_result(first);
		step();
		check_word({op_name(second), " valid next cycle"}, 1, bit_word(cdb_valid));
		check_result(second);
		check_word({op_name(first), " ready after bus"}, 1,
			bit_word(ready_of(g_unit[first])));
		check_word({op_name(second), " ready while waiting"}, '0,
			bit_word(ready_of(g_unit[second])));
		last_log = g_unit[second];
		step();
		check_word({op_name(second), " ready after bus"}, 1,
			bit_word(ready_of(g_unit[second])));
	endtask

	initial begin
		rst = 1'b1;
		add_valid_in = 1'b0;
		log_valid_in = 1'b0;
		add_op = '0;
		log_op = '0;
		add_rob_tag = '0;
		log_rob_tag = '0;
		add_rs1 = '0;
		add_rs2 = '0;
		log_rs1 = '0;
		log_rs2 = '0;
		rng = 32'h118b_77fa;
		last_log = 1'b1; // add wins the first tie
		n_ops_done = 0;
		load_golden();

		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		check_word("reset add ready", 1, bit_word(add_ready));
		check_word("reset log ready", 1, bit_word(log_ready));
		check_word("reset cdb_valid", '0, bit_word(cdb_valid));

		idx = 0;
		while (idx < g_unit.size()) begin
			if (g_pair[idx]) begin
				if (idx + 1 >= g_unit.size())
					abort_run("golden file ends inside a pair");
				run_pair(idx, idx + 1);
				idx += 2;
			end else begin
				run_single(idx);
				idx += 1;
			end
			rng = xorshift(rng);
			repeat (rng[1:0]) step(); // idle gap
		end

		if (n_ops_done > 0 && n_ops_done == g_unit.size()) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("no operations were checked from the golden file");
			$display("Some tests failed");
			$fatal(1);
		end
	end

endmodule

/* source/exec_cluster.sv */
// integer execute cluster top: add unit, logic unit and cdb arbiter
// issue ports per unit in, one common data bus result per cycle out
`timescale 1ns/100ps

module exec_cluster (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  add_valid_in,
	input  exec_op_pkg::exec_op_u add_op,
	input  cpu_pkg::rob_tag_t     add_rob_tag,
	input  cpu_pkg::word_t        add_rs1,
	input  cpu_pkg::word_t        add_rs2,
	output logic                  add_ready,
	input  logic                  log_valid_in,
	input  exec_op_pkg::exec_op_u log_op,
	input  cpu_pkg::rob_tag_t     log_rob_tag,
	input  cpu_pkg::word_t        log_rs1,
	input  cpu_pkg::word_t        log_rs2,
	output logic                  log_ready,
	output logic                  cdb_valid,
	output cpu_pkg::rob_tag_t     cdb_tag,
	output cpu_pkg::word_t        cdb_result,
	output logic                  cdb_branch_taken
);

	logic add_done, add_yumi, add_branch_taken;
	cpu_pkg::word_t add_result;
	cpu_pkg::rob_tag_t add_tag;
	logic log_done, log_yumi;
	cpu_pkg::word_t log_result;
	cpu_pkg::rob_tag_t log_tag;

	add_unit u_add_unit (
		.clk          (clk),
		.rst          (rst),
		.valid_in     (add_valid_in),
		.op           (add_op),
		.rob_tag      (add_rob_tag),
		.rs1          (add_rs1),
		.rs2          (add_rs2),
		.yumi         (add_yumi),
		.ready        (add_ready),
		.done         (add_done),
		.result       (add_result),
		.tag          (add_tag),
		.branch_taken (add_branch_taken)
	);

	logic_unit u_logic_unit (
		.clk      (clk),
		.rst      (rst),
		.valid_in (log_valid_in),
		.op       (log_op),
		.rob_tag  (log_rob_tag),
		.rs1      (log_rs1),
		.rs2      (log_rs2),
		.yumi     (log_yumi),
		.ready    (log_ready),
		.done     (log_done),
		.result   (log_result),
		.tag      (log_tag)
	);

	cdb_arbiter u_cdb_arbiter (
		.clk              (clk),
		.rst              (rst),
		.add_done         (add_done),
		.add_result       (add_result),
		.add_tag          (add_tag),
		.add_branch_taken (add_branch_taken),
		.log_done         (log_done),
		.log_result       (log_result),
		.log_tag          (log_tag),
		.add_yumi         (add_yumi),
		.log_yumi         (log_yumi),
		.cdb_valid        (cdb_valid),
		.cdb_tag          (cdb_tag),
		.cdb_result       (cdb_result),
		.cdb_branch_taken (cdb_branch_taken)
	);

endmodule

/* source/cdb_arbiter.sv */
// picks one finished result per cycle for the common data bus
// round-robin between the add and logic units, add first after reset
// the chosen unit gets a one-cycle yumi in the same cycle
`timescale 1ns/100ps

module cdb_arbiter (
	input  logic              clk,
	input  logic              rst,
	input  logic              add_done,
	input  cpu_pkg::word_t    add_result,
	input  cpu_pkg::rob_tag_t add_tag,
	input  logic              add_branch_taken,
	input  logic              log_done,
	input  cpu_pkg::word_t    log_result,
	input  cpu_pkg::rob_tag_t log_tag,
	output logic              add_yumi,
	output logic              log_yumi,
	output logic              cdb_valid,
	output cpu_pkg::rob_tag_t cdb_tag,
	output cpu_pkg::word_t    cdb_result,
	output logic              cdb_branch_taken
);

	logic last_was_log; // owner of the previous grant

	// on a tie the unit not granted last wins
	assign add_yumi = add_done & (~log_done | last_was_log);
	assign log_yumi = log_done & (~add_done | ~last_was_log);

	always_ff @(posedge clk) begin
		if (rst) begin
			last_was_log <= 1'b1; // so add wins the first tie
		end else if (add_yumi | log_yumi) begin
			last_was_log <= log_yumi;
		end
	end

	always_comb begin
		cdb_valid = add_yumi | log_yumi;
		if (add_yumi) begin
			cdb_tag = add_tag;
			cdb_result = add_result;
			cdb_branch_taken = add_branch_taken;
		end else if (log_yumi) begin
			cdb_tag = log_tag;
			cdb_result = log_result;
			cdb_branch_taken = 1'b0; // logic ops never branch
		end else begin
			cdb_tag = '0;
			cdb_result = '0;
			cdb_branch_taken = 1'b0;
		end
	end

endmodule

/* source/logic_unit.sv */
// bitwise and shift functional unit
// same issue and hold behaviour as the add unit, no branch output
`timescale 1ns/100ps

module logic_unit (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    valid_in,
	input  exec_op_pkg::exec_op_u   op,
	input  cpu_pkg::rob_tag_t       rob_tag,
	input  cpu_pkg::word_t          rs1,
	input  cpu_pkg::word_t          rs2,
	input  logic                    yumi,
	output logic                    ready,
	output logic                    done,
	output cpu_pkg::word_t          result,
	output cpu_pkg::rob_tag_t       tag
);

	cpu_pkg::word_t calc;
	logic [cpu_pkg::shamt_w-1:0] shamt;

	assign shamt = rs2[cpu_pkg::shamt_w-1:0]; // low bits only

	always_comb begin
		case (op.logical.logic_fn)
			exec_op_pkg::fn_and: calc = rs1 & rs2;
			exec_op_pkg::fn_or:  calc = rs1 | rs2;
			exec_op_pkg::fn_xor: calc = rs1 ^ rs2;
			exec_op_pkg::fn_sll: calc = rs1 << shamt;
			exec_op_pkg::fn_srl: calc = rs1 >> shamt; // logical, zero fill
			default:             calc = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			done <= 1'b0;
		end else if (yumi) begin
			done <= 1'b0;
		end else if (valid_in) begin
			done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_in && !done) begin
			result <= calc;
			tag <= rob_tag;
		end
	end

	assign ready = ~done;

endmodule

/* source/add_unit.sv */
// add/subtract functional unit that also resolves bne, beq and blt
// accepts one op while ready, holds the result with done high until yumi
`timescale 1ns/100ps

module add_unit (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    valid_in,
	input  exec_op_pkg::exec_op_u   op,
	input  cpu_pkg::rob_tag_t       rob_tag,
	input  cpu_pkg::word_t          rs1,
	input  cpu_pkg::word_t          rs2,
	input  logic                    yumi,
	output logic                    ready,
	output logic                    done,
	output cpu_pkg::word_t          result,
	output cpu_pkg::rob_tag_t       tag,
	output logic                    branch_taken
);

	cpu_pkg::word_t sum;
	logic zero, negative, overflow;
	logic do_sub;
	logic taken;

	// any branch needs the difference
	assign do_sub = op.arith.sub | (op.arith.branch_type != exec_op_pkg::br_none);

	add_sub_core u_add_sub_core (
		.a        (rs1),
		.b        (rs2),
		.sub      (do_sub),
		.sum      (sum),
		.zero     (zero),
		.negative (negative),
		.overflow (overflow)
	);

	always_comb begin
		case (op.arith.branch_type)
			exec_op_pkg::br_ne: taken = ~zero;
			exec_op_pkg::br_eq: taken = zero;
			exec_op_pkg::br_lt: taken = negative ^ overflow; // signed less than
			default:            taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			done <= 1'b0;
		end else if (yumi) begin
			done <= 1'b0;
		end else if (valid_in) begin
			done <= 1'b1;
		end
	end

	// payload, only loaded on accept
	always_ff @(posedge clk) begin
		if (valid_in && !done) begin
			result <= sum;
			tag <= rob_tag;
			branch_taken <= taken;
		end
	end

	assign ready = ~done; // busy until the bus takes the result

endmodule

/* source/add_sub_core.sv */
// 32-bit ripple-carry adder/subtractor with zero, negative and overflow flags
// purely combinational, used by the add unit for add, sub and branch compare
`timescale 1ns/100ps

module add_sub_core (
	input  cpu_pkg::word_t a,
	input  cpu_pkg::word_t b,
	input  logic           sub,
	output cpu_pkg::word_t sum,
	output logic           zero,
	output logic           negative,
	output logic           overflow
);

	cpu_pkg::word_t b_eff;
	logic [cpu_pkg::xlen:0] carry;
	logic [cpu_pkg::xlen/4-1:0] nib_any;
	logic [1:0] half_any;

	assign b_eff = sub ? ~b : b; // invert and carry in one for subtract
	assign carry[0] = sub;

	genvar i;
	generate
		for (i = 0; i < cpu_pkg::xlen; i++) begin : g_bit
			logic p, g, c_mid;
			// first half adder on the operands
			assign p = a[i] ^ b_eff[i];
			assign g = a[i] & b_eff[i];
			// second half adder adds the carry in
			assign sum[i] = p ^ carry[i];
			assign c_mid = p & carry[i];
			assign carry[i+1] = g | c_mid;
		end
	endgenerate

	// or tree, nibbles first
	genvar j;
	generate
		for (j = 0; j < cpu_pkg::xlen/4; j++) begin : g_nib
			assign nib_any[j] = |sum[4*j +: 4];
		end
	endgenerate

	assign half_any[0] = |nib_any[cpu_pkg::xlen/8-1:0];
	assign half_any[1] = |nib_any[cpu_pkg::xlen/4-1:cpu_pkg::xlen/8];
	assign zero = ~(half_any[0] | half_any[1]);

	assign negative = sum[cpu_pkg::xlen-1];
	assign overflow = carry[cpu_pkg::xlen-1] ^ carry[cpu_pkg::xlen]; // carry in vs out of msb

endmodule

/* source/exec_op_pkg.sv */
// operation word handed to each functional unit at issue
// the add unit reads the arith view, the logic unit the logic view
package exec_op_pkg;

	// conditional branch kinds, all resolved by a subtract
	typedef enum logic [1:0] {
		br_none = 2'd0,
		br_ne   = 2'd1,
		br_eq   = 2'd2,
		br_lt   = 2'd3
	} branch_type_e;

	// logic unit functions
	typedef enum logic [2:0] {
		fn_and = 3'd0,
		fn_or  = 3'd1,
		fn_xor = 3'd2,
		fn_sll = 3'd3,
		fn_srl = 3'd4
	} logic_fn_e;

	typedef struct packed {
		branch_type_e branch_type;
		logic sub; // plain subtract when no branch
	} arith_view_t;

	typedef struct packed {
		logic_fn_e logic_fn;
	} logic_view_t;

	// same three bits, decoded per unit
	typedef union packed {
		arith_view_t arith;
		logic_view_t logical;
	} exec_op_u;

endpackage

/* source/cpu_pkg.sv */
// widths and word types shared by the integer execute cluster
// units, arbiter and top level reference these by scoped name
package cpu_pkg;

	// datapath
	localparam int xlen = 32; // operand and result width
	localparam int shamt_w = $clog2(xlen); // shift amount taken from rs2

	// reorder buffer
	localparam int rob_tag_w = 4; // one tag per rob entry

	// common data bus fields
	typedef logic [xlen-1:0] word_t;
	typedef logic [rob_tag_w-1:0] rob_tag_t;

endpackage
